/* logic/i2cBusPkg.sv */
/*
 * register bus types, register offsets and the bit positions
 * of the data and status register fields
 */

package i2cBusPkg;

    // one word on the register bus
    typedef logic [31:0] busWord_t;

    // one-bit register offset
    typedef logic regAddr_t;

    localparam regAddr_t dataRegAddr   = 1'b0;
    localparam regAddr_t statusRegAddr = 1'b1;

    // data register fields
    localparam int byteLsb = 0;
    localparam int byteMsb = 7;
    localparam int ackBit  = 8;
    localparam int cmdLsb  = 9;
    localparam int cmdMsb  = 10;

    // status register fields
    localparam int transmitReadyBit = 0;
    localparam int receiveValidBit  = 1;

endpackage

/* logic/i2cLinePkg.sv */
/*
 * I2C line side types: data byte, command code and the four command values
 */

package i2cLinePkg;

    // one byte on the I2C wire
    typedef logic [7:0] byte_t;

    // command field of the data register
    typedef logic [1:0] command_t;

    // start doubles as repeated start
    localparam command_t cmdStart = 2'd0;
    localparam command_t cmdStop  = 2'd1;
    localparam command_t cmdWrite = 2'd2;
    localparam command_t cmdRead  = 2'd3;

endpackage

/* logic/i2cBitTimer.sv */
/*
 * quarter-period tick generator for SCL, held while a target stretches the clock
 */

`timescale 1ns/1ps

module i2cBitTimer #(
    parameter int quarterPeriod = 5
) (
    input  logic clk,
    input  logic reset,
    input  logic tickEnable,
    input  logic sclReleased,
    input  logic sclLine,
    output logic quarterTick
);

    localparam int countWidth = $clog2(quarterPeriod + 1);
    localparam logic [countWidth-1:0] reload = countWidth'(quarterPeriod - 1);

    logic [countWidth-1:0] count;
    logic                  stretch;

    // SCL let go but still held low by the target
    assign stretch = sclReleased && !sclLine;

    assign quarterTick = tickEnable && !stretch && (count == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= reload;
        end else if (!tickEnable) begin
            count <= reload;
        end else if (stretch) begin
            count <= count;
        end else if (count == '0) begin
            count <= reload;
        end else begin
            count <= count - countWidth'(1);
        end
    end

endmodule

/* logic/i2cCore.sv */
/*
 * I2C command sequencer: start, stop, byte write and byte read as
 * quarter-period bit sequences, with shift, acknowledge and valid registers
 */

`timescale 1ns/1ps

module i2cCore #(
    parameter int quarterPeriod = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  i2cLinePkg::command_t commandIn,
    input  i2cLinePkg::byte_t    transmitDataIn,
    input  logic                 transmitAckIn,
    input  logic                 transmitDataLoadEn,
    input  logic                 receiveDataReadReq,
    output i2cLinePkg::byte_t    receiveData,
    output logic                 receiveAck,
    output logic                 receiveValid,
    output logic                 transmitReady,
    inout  wire                  scl,
    inout  wire                  sda
);

    import i2cLinePkg::*;

    typedef enum logic [2:0] {stIdle, stStart, stStop, stBit, stAck} state_t;

    state_t   state;
    logic [1:0] quarter;
    logic [2:0] bitCount;
    byte_t    shiftReg;
    command_t cmdReg;
    logic     masterAck;
    logic     sdaRelease;
    logic     sclLow;
    logic     sclSample;
    logic     sdaSample;
    logic     quarterTick;
    logic     accept;
    logic     byteDone;
    logic     isRead;

    assign transmitReady = (state == stIdle);
    assign accept        = transmitDataLoadEn && transmitReady;
    assign isRead        = (cmdReg == cmdRead);
    assign byteDone      = quarterTick && (state == stAck) && (quarter == 2'd3);
    assign receiveData   = shiftReg;

    // SCL low in the first half of every bit, released in idle
    assign sclLow = !transmitReady && !quarter[1];
    assign scl    = sclLow ? 1'b0 : 1'bz;
    assign sda    = sdaRelease ? 1'bz : 1'b0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sclSample <= 1'b1;
            sdaSample <= 1'b1;
        end else begin
            sclSample <= scl;
            sdaSample <= sda;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= stIdle;
            quarter    <= 2'd0;
            bitCount   <= 3'd0;
            sdaRelease <= 1'b1;
        end else if (accept) begin
            quarter  <= 2'd0;
            bitCount <= 3'd0;
            case (commandIn)
                cmdStart:          state <= stStart;
                cmdStop:           state <= stStop;
                cmdWrite, cmdRead: state <= stBit;
                default:           state <= stIdle;
            endcase
        end else if (quarterTick) begin
            quarter <= quarter + 2'd1;
            case (state)
                stStart: begin
                    // SDA falls while SCL is high
                    if (quarter == 2'd0) sdaRelease <= 1'b1;
                    if (quarter == 2'd2) sdaRelease <= 1'b0;
                    if (quarter == 2'd3) state <= stIdle;
                end
                stStop: begin
                    // SDA rises while SCL is high
                    if (quarter == 2'd0) sdaRelease <= 1'b0;
                    if (quarter == 2'd2) sdaRelease <= 1'b1;
                    if (quarter == 2'd3) state <= stIdle;
                end
                stBit: begin
                    if (quarter == 2'd0) sdaRelease <= isRead || shiftReg[7];
                    if (quarter == 2'd3) begin
                        bitCount <= bitCount + 3'd1;
                        if (bitCount == 3'd7) state <= stAck;
                    end
                end
                stAck: begin
                    // master acks on a read, target acks on a write
                    if (quarter == 2'd0) sdaRelease <= isRead ? masterAck : 1'b1;
                    if (quarter == 2'd3) state <= stIdle;
                end
                default: ;
            endcase
        end
    end

    // shift in on the third quarter, MSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg  <= transmitDataIn;
            cmdReg    <= commandIn;
            masterAck <= transmitAckIn;
        end else if (quarterTick && quarter == 2'd2) begin
            if (state == stBit) shiftReg <= {shiftReg[6:0], sdaSample};
            if (state == stAck) receiveAck <= sdaSample;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            receiveValid <= 1'b0;
        end else if (byteDone) begin
            receiveValid <= 1'b1;
        end else if (receiveDataReadReq) begin
            receiveValid <= 1'b0;
        end
    end

    i2cBitTimer #(
        .quarterPeriod (quarterPeriod)
    ) i2cBitTimer (
        .clk           (clk),
        .reset         (reset),
        .tickEnable    (!transmitReady),
        .sclReleased   (!sclLow),
        .sclLine       (sclSample),
        .quarterTick   (quarterTick)
    );

endmodule

/* logic/i2c.sv */
/*
 * register bus interface of the I2C controller: bus input registers,
 * data register write decoder, read multiplexer and status read strobe
 */

`timescale 1ns/1ps

module i2c #(
    parameter int quarterPeriod = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                write,
    input  i2cBusPkg::regAddr_t address,
    input  i2cBusPkg::busWord_t dataIn,
    output logic                readValid,
    output i2cBusPkg::busWord_t dataOut,
    inout  wire                 scl,
    inout  wire                 sda
);

    import i2cBusPkg::*;
    import i2cLinePkg::*;

    // registered bus inputs
    busWord_t dataInReg;
    logic     readReg;
    logic     writeReg;
    regAddr_t addressReg;
    busWord_t readMux;

    // core side
    command_t commandIn;
    byte_t    transmitDataIn;
    logic     transmitAckIn;
    logic     transmitDataLoadEn;
    logic     receiveDataReadReq;
    byte_t    receiveData;
    logic     receiveAck;
    logic     receiveValid;
    logic     transmitReady;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readReg    <= 1'b0;
            writeReg   <= 1'b0;
            readValid  <= 1'b0;
            addressReg <= dataRegAddr;
        end else begin
            readReg    <= read;
            writeReg   <= write;
            readValid  <= readReg;
            addressReg <= address;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        dataInReg <= dataIn;
        dataOut   <= readMux;
    end

    // only the data register takes writes
    assign transmitDataLoadEn = writeReg && (addressReg == dataRegAddr);

    // fields of the data register
    assign commandIn      = dataInReg[cmdMsb:cmdLsb];
    assign transmitDataIn = dataInReg[byteMsb:byteLsb];
    assign transmitAckIn  = dataInReg[ackBit];

    always_comb begin
        readMux = '0;
        case (addressReg)
            dataRegAddr: begin
                readMux[byteMsb:byteLsb] = receiveData;
                readMux[ackBit]          = receiveAck;
            end
            statusRegAddr: begin
                readMux[transmitReadyBit] = transmitReady;
                readMux[receiveValidBit]  = receiveValid;
            end
            default: ;
        endcase
    end

    // a status read clears receiveValid
    assign receiveDataReadReq = readReg && (addressReg == statusRegAddr);

    i2cCore #(
        .quarterPeriod      (quarterPeriod)
    ) i2cCore (
        .clk                (clk),
        .reset              (reset),
        .commandIn          (commandIn),
        .transmitDataIn     (transmitDataIn),
        .transmitAckIn      (transmitAckIn),
        .transmitDataLoadEn (transmitDataLoadEn),
        .receiveDataReadReq (receiveDataReadReq),
        .receiveData        (receiveData),
        .receiveAck         (receiveAck),
        .receiveValid       (receiveValid),
        .transmitReady      (transmitReady),
        .scl                (scl),
        .sda                (sda)
    );

endmodule

/* logic/i2cSystem.sv */
/*
 * top level: register bus and open-drain I2C pins to the controller
 */

`timescale 1ns/1ps

module i2cSystem #(
    parameter int quarterPeriod = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                read,
    input  logic                write,
    input  i2cBusPkg::regAddr_t address,
    input  i2cBusPkg::busWord_t dataIn,
    output logic                readValid,
    output i2cBusPkg::busWord_t dataOut,
    inout  wire                 scl,
    inout  wire                 sda
);

    i2c #(
        .quarterPeriod (quarterPeriod)
    ) i2c (
        .clk           (clk),
        .reset         (reset),
        .read          (read),
        .write         (write),
        .address       (address),
        .dataIn        (dataIn),
        .readValid     (readValid),
        .dataOut       (dataOut),
        .scl           (scl),
        .sda           (sda)
    );

endmodule

/* verification/i2cTb_assert.sv */
/*
 * concurrent checks on the register bus timing of the I2C controller
 */

`timescale 1ns/1ps

module i2cTb_assert (
    input logic                clk,
    input logic                reset,
    input logic                read,
    input logic                write,
    input i2cBusPkg::regAddr_t address,
    input i2cBusPkg::busWord_t dataOut,
    input logic                readValid,
    input logic                transmitReady
);

    import i2cBusPkg::*;

    readLatency: assert property (@(posedge clk) disable iff (reset)
        read |-> ##2 readValid)
        else $error("readValid did not follow a read strobe by two cycles");

    // no readValid without a read two cycles before
    readValidSource: assert property (@(posedge clk) disable iff (reset)
        readValid |-> $past(read, 2))
        else $error("readValid without a matching read strobe");

    statusUpperZero: assert property (@(posedge clk) disable iff (reset)
        (read && address == statusRegAddr) |-> ##2 (dataOut[31:2] == '0))
        else $error("status register upper bits are not zero");

    writeAccepted: assert property (@(posedge clk) disable iff (reset)
        (write && address == dataRegAddr && transmitReady) |-> ##2 !transmitReady)
        else $error("transmitReady still high after an accepted write");

endmodule

bind i2c i2cTb_assert busTiming (
    .clk           (clk),
    .reset         (reset),
    .read          (read),
    .write         (write),
    .address       (address),
    .dataOut       (dataOut),
    .readValid     (readValid),
    .transmitReady (transmitReady)
);

/* verification/i2cTb.sv */
/*
 * testbench for the I2C controller: clock, reset, bus tasks,
 * behavioral I2C target with clock stretching, memory model and checks
 */

`timescale 1ns/1ps

module i2cTb;

    import i2cBusPkg::*;
    import i2cLinePkg::*;

    localparam int qp = 5;
    localparam logic [6:0] targetAddr = 7'h3A;

    logic     clk = 1'b0;
    logic     reset;
    logic     read;
    logic     write;
    regAddr_t address;
    busWord_t dataIn;
    logic     readValid;
    busWord_t dataOut;
    wire      scl;
    wire      sda;

    integer   seed = 32'h3970_bea2;
    integer   stretchSeed = 32'h3970_bea2;
    byte_t    modelMem [8];
    logic     sdaHold;
    logic     sclHold;

    pullup (scl);
    pullup (sda);
    assign scl = sclHold ? 1'b0 : 1'bz;
    assign sda = sdaHold ? 1'b0 : 1'bz;

    always #2 clk = ~clk;

    i2cSystem #(
        .quarterPeriod (qp)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .read      (read),
        .write     (write),
        .address   (address),
        .dataIn    (dataIn),
        .readValid (readValid),
        .dataOut   (dataOut),
        .scl       (scl),
        .sda       (sda)
    );

    // target holds SCL low past the master's low phase on random bits
    initial begin
        integer r;
        integer n;
        sclHold = 1'b0;
        forever begin
            @(negedge scl);
            r = $random(stretchSeed);
            if (r[0]) begin
                n = 2 * qp + ((r >>> 1) & 32'h7fff) % 21;
                sclHold = 1'b1;
                repeat (n) @(posedge clk);
                sclHold = 1'b0;
            end
        end
    end

    // behavioral target with an eight-byte register memory
    initial begin
        byte_t    mem [8];
        byte_t    shift;
        byte_t    txByte;
        logic [2:0] ptr;
        logic     active;
        logic     txMode;
        logic     masterNack;
        logic     sclPrev;
        logic     sdaPrev;
        int       cnt;
        int       phase;
        for (int i = 0; i < 8; i++) begin
            mem[i] = byte_t'(i) * 8'h2B + 8'h5A;
        end
        sdaHold = 1'b0;
        active = 1'b0;
        txMode = 1'b0;
        masterNack = 1'b0;
        ptr = 3'd0;
        cnt = 0;
        phase = 0;
        shift = 8'h00;
        txByte = 8'h00;
        sclPrev = 1'b1;
        sdaPrev = 1'b1;
        forever begin
            @(scl or sda);
            if (scl === 1'b1 && sclPrev === 1'b1 && sda !== sdaPrev) begin
                // start or stop condition
                active = (sda === 1'b0);
                cnt = 0;
                phase = 0;
                txMode = 1'b0;
                sdaHold = 1'b0;
            end else if (active && scl === 1'b1 && sclPrev !== 1'b1) begin
                if (cnt < 8) begin
                    if (!txMode) shift = {shift[6:0], sda};
                end else if (txMode) begin
                    masterNack = sda;
                end
                cnt = cnt + 1;
            end else if (active && scl === 1'b0 && sclPrev === 1'b1) begin
                if (cnt == 8) begin
                    if (txMode) begin
                        sdaHold = 1'b0;
                    end else if (phase == 0) begin
                        if (shift[7:1] == targetAddr) begin
                            sdaHold = 1'b1;
                            txMode = shift[0];
                            phase = 1;
                        end else begin
                            active = 1'b0;
                        end
                    end else if (phase == 1) begin
                        ptr = shift[2:0];
                        sdaHold = 1'b1;
                        phase = 2;
                    end else begin
                        mem[ptr] = shift;
                        ptr = ptr + 3'd1;
                        sdaHold = 1'b1;
                    end
                end else if (cnt == 9) begin
                    cnt = 0;
                    sdaHold = 1'b0;
                    if (txMode) begin
                        if (phase == 2 && masterNack) begin
                            active = 1'b0;
                        end else begin
                            phase = 2;
                            txByte = mem[ptr];
                            ptr = ptr + 3'd1;
                            sdaHold = !txByte[7];
                        end
                    end
                end else if (txMode && cnt >= 1) begin
                    sdaHold = !txByte[7 - cnt];
                end
            end
            sclPrev = scl;
            sdaPrev = sda;
        end
    end

    task automatic endWithFailure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input busWord_t got, input busWord_t exp);
        if (got !== exp) begin
            endWithFailure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkByte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            endWithFailure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            endWithFailure($sformatf("mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic busRead(input regAddr_t addr, output busWord_t word);
        int waits;
        waits = 0;
        @(negedge clk);
        read = 1'b1;
        address = addr;
        do begin
            @(negedge clk);
            waits++;
            if (waits == 1) read = 1'b0;
        end while (!readValid && waits < 8);
        if (!readValid) endWithFailure("timeout waiting for readValid");
        if (waits != 2) endWithFailure("readValid did not come two cycles after the read");
        word = dataOut;
    endtask

    // issue a command, then poll status until the core is ready again
    task automatic busWrite(input command_t cmd, input byte_t data, input logic ack,
                            input logic pokeBusy, output busWord_t status);
        int polls;
        polls = 0;
        status = '0;
        @(negedge clk);
        write = 1'b1;
        address = dataRegAddr;
        dataIn = {21'b0, cmd, ack, data};
        @(negedge clk);
        write = 1'b0;
        while (!status[transmitReadyBit] && polls < 2000) begin
            busRead(statusRegAddr, status);
            polls++;
            if (pokeBusy && polls == 1) begin
                // must be ignored by the busy core
                @(negedge clk);
                write = 1'b1;
                address = dataRegAddr;
                dataIn = {21'b0, cmdStop, 1'b1, 8'hFF};
                @(negedge clk);
                write = 1'b0;
            end
        end
        if (!status[transmitReadyBit]) endWithFailure("timeout waiting for transmitReady");
    endtask

    task automatic issueCommand(input command_t cmd);
        busWord_t st;
        busWrite(cmd, 8'h00, 1'b0, 1'b0, st);
    endtask

    task automatic sendByte(input byte_t data, input logic expAck, input logic pokeBusy);
        busWord_t st;
        busWord_t w;
        busWrite(cmdWrite, data, 1'b0, pokeBusy, st);
        checkBit("receiveValid", st[receiveValidBit], 1'b1);
        busRead(dataRegAddr, w);
        checkBit("receiveAck", w[ackBit], expAck);
    endtask

    task automatic writeTransaction();
        logic [2:0] ptr;
        int         count;
        integer     r;
        r = $random(seed);
        ptr = r[2:0];
        count = 1 + ((r >>> 3) & 32'hff) % 4;
        issueCommand(cmdStart);
        sendByte({targetAddr, 1'b0}, 1'b0, 1'b0);
        sendByte({5'b0, ptr}, 1'b0, 1'b0);
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            sendByte(r[7:0], 1'b0, r[8]);
            modelMem[ptr] = r[7:0];
            ptr = ptr + 3'd1;
        end
        issueCommand(cmdStop);
    endtask

    task automatic readTransaction();
        logic [2:0] ptr;
        int         count;
        integer     r;
        logic       last;
        busWord_t   st;
        busWord_t   w;
        r = $random(seed);
        ptr = r[2:0];
        count = 1 + ((r >>> 3) & 32'hff) % 8;
        issueCommand(cmdStart);
        sendByte({targetAddr, 1'b0}, 1'b0, 1'b0);
        sendByte({5'b0, ptr}, 1'b0, 1'b0);
        // repeated start into read mode
        issueCommand(cmdStart);
        sendByte({targetAddr, 1'b1}, 1'b0, 1'b0);
        for (int i = 0; i < count; i++) begin
            last = (i == count - 1);
            busWrite(cmdRead, 8'h00, last, r[12 + i], st);
            checkBit("receiveValid", st[receiveValidBit], 1'b1);
            busRead(dataRegAddr, w);
            checkByte("receiveData", w[byteMsb:byteLsb], modelMem[ptr]);
            checkBit("receiveAck", w[ackBit], last);
            ptr = ptr + 3'd1;
        end
        issueCommand(cmdStop);
    endtask

    initial begin
        busWord_t w;
        integer   r;
        logic [6:0] badAddr;
        reset = 1'b1;
        read = 1'b0;
        write = 1'b0;
        address = dataRegAddr;
        dataIn = '0;
        for (int i = 0; i < 8; i++) begin
            modelMem[i] = byte_t'(i) * 8'h2B + 8'h5A;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        busRead(statusRegAddr, w);
        checkWord("status", w, 32'h0000_0001);

        // address acknowledge, then receiveValid cleared by the status read
        issueCommand(cmdStart);
        sendByte({targetAddr, 1'b0}, 1'b0, 1'b0);
        busRead(statusRegAddr, w);
        checkBit("receiveValid", w[receiveValidBit], 1'b0);
        issueCommand(cmdStop);

        r = $random(seed);
        badAddr = r[6:0];
        if (badAddr == targetAddr) badAddr = badAddr ^ 7'h01;
        issueCommand(cmdStart);
        sendByte({badAddr, 1'b0}, 1'b1, 1'b0);
        issueCommand(cmdStop);

        for (int t = 0; t < 8; t++) begin
            writeTransaction();
            readTransaction();
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
logic/i2cBusPkg.sv
logic/i2cLinePkg.sv
logic/i2cBitTimer.sv
logic/i2cCore.sv
logic/i2c.sv
logic/i2cSystem.sv
verification/i2cTb_assert.sv
verification/i2cTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "help   list the targets"
	@echo "test   build with Verilator and run the testbench"
	@echo "clean  remove build output"

test:
	verilator --binary --timing --assert -f all.f --top-module i2cTb -Mdir obj_dir -o i2cSim
	./obj_dir/i2cSim | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
